// ==== cpu_pkg.sv ====
package cpu_pkg;

    localparam int word_size = 16;
    localparam int reg_addr_bits = 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction fields.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int op_msb = 15;
    localparam int op_lsb = 12;
    localparam int rs_msb = 11;
    localparam int rs_lsb = 10;
    localparam int rt_msb = 9;
    localparam int rt_lsb = 8;
    localparam int rd_msb = 7;
    localparam int rd_lsb = 6;
    localparam int func_msb = 5;
    localparam int func_lsb = 0;
    localparam int imm_msb = 7;
    localparam int imm_lsb = 0;
    localparam int imm_bits = imm_msb - imm_lsb + 1;

    // I-type ops write rt, R-type ops write rd.
    typedef enum logic [3:0] {
        op_adi   = 4'd4,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_rtype = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_wwd = 6'd28,
        fn_hlt = 6'd29
    } func_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_orr
    } alu_op_e;

endpackage

// ==== id_ex_if.sv ====
interface id_ex_if;

    logic [cpu_pkg::word_size-1:0]     r_data1;
    logic [cpu_pkg::word_size-1:0]     r_data2;
    logic [cpu_pkg::word_size-1:0]     imm;
    cpu_pkg::alu_op_e                  alu_op;
    logic                              use_imm;
    logic [cpu_pkg::reg_addr_bits-1:0] rd;

    // Control bits, all zero in a bubble.
    logic mem_read, mem_write;
    logic reg_write, mem_to_reg;
    logic is_wwd, is_done;

    modport producer (
        output r_data1, r_data2, imm, alu_op, use_imm, rd,
        output mem_read, mem_write, reg_write, mem_to_reg, is_wwd, is_done
    );

    modport consumer (
        input r_data1, r_data2, imm, alu_op, use_imm, rd,
        input mem_read, mem_write, reg_write, mem_to_reg, is_wwd, is_done
    );

endinterface

// ==== ex_mem_if.sv ====
interface ex_mem_if;

    logic [cpu_pkg::word_size-1:0]     alu_result;
    logic [cpu_pkg::word_size-1:0]     r_data1;
    logic [cpu_pkg::word_size-1:0]     r_data2;
    logic [cpu_pkg::reg_addr_bits-1:0] rd;

    logic mem_read, mem_write;
    logic reg_write, mem_to_reg;
    logic is_wwd, is_done;

    modport producer (
        output alu_result, r_data1, r_data2, rd,
        output mem_read, mem_write, reg_write, mem_to_reg, is_wwd, is_done
    );

    modport consumer (
        input alu_result, r_data1, r_data2, rd,
        input mem_read, mem_write, reg_write, mem_to_reg, is_wwd, is_done
    );

endinterface

// ==== id_stage.sv ====
module id_stage #(
    parameter logic [cpu_pkg::word_size-1:0] pc_reset = '0
) (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic [cpu_pkg::word_size-1:0]     i_data,
    input  logic                              mem_reg_write,
    input  logic [cpu_pkg::reg_addr_bits-1:0] mem_rd,
    input  logic                              wb_reg_write,
    input  logic [cpu_pkg::reg_addr_bits-1:0] wb_rd,
    input  logic [cpu_pkg::word_size-1:0]     wb_data,
    output logic [cpu_pkg::word_size-1:0]     i_addr,
    id_ex_if.producer                         de
);

    logic [cpu_pkg::word_size-1:0]     pc;
    logic [cpu_pkg::word_size-1:0]     regs [2**cpu_pkg::reg_addr_bits];
    logic                              halt_seen;

    cpu_pkg::opcode_e                  opcode;
    cpu_pkg::func_e                    func;
    logic [cpu_pkg::reg_addr_bits-1:0] rs, rt, rd, dest;
    logic [cpu_pkg::word_size-1:0]     imm, rdata1, rdata2;

    cpu_pkg::alu_op_e                  alu_op;
    logic use_imm, mem_read, mem_write, reg_write, mem_to_reg;
    logic is_wwd, is_done, use_rs, use_rt;
    logic hazard_ex, hazard_mem, wwd_gap, stall, issue;

    assign i_addr = pc;

    assign opcode = cpu_pkg::opcode_e'(i_data[cpu_pkg::op_msb:cpu_pkg::op_lsb]);
    assign func = cpu_pkg::func_e'(i_data[cpu_pkg::func_msb:cpu_pkg::func_lsb]);
    assign rs = i_data[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
    assign rt = i_data[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
    assign rd = i_data[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
    assign imm = {{(cpu_pkg::word_size - cpu_pkg::imm_bits){i_data[cpu_pkg::imm_msb]}},
                  i_data[cpu_pkg::imm_msb:cpu_pkg::imm_lsb]};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoder.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        alu_op = cpu_pkg::alu_add;
        use_imm = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        mem_to_reg = 1'b0;
        is_wwd = 1'b0;
        is_done = 1'b0;
        use_rs = 1'b0;
        use_rt = 1'b0;
        dest = rt;
        case (opcode)
            cpu_pkg::op_rtype: begin
                dest = rd;
                case (func)
                    cpu_pkg::fn_sub: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and: alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_orr: alu_op = cpu_pkg::alu_orr;
                    default:         alu_op = cpu_pkg::alu_add;
                endcase
                case (func)
                    cpu_pkg::fn_add, cpu_pkg::fn_sub, cpu_pkg::fn_and, cpu_pkg::fn_orr: begin
                        use_rs = 1'b1;
                        use_rt = 1'b1;
                        reg_write = 1'b1;
                    end
                    cpu_pkg::fn_wwd: begin
                        use_rs = 1'b1;
                        is_wwd = 1'b1;
                    end
                    cpu_pkg::fn_hlt: is_done = 1'b1;
                    default: ;
                endcase
            end
            cpu_pkg::op_adi: begin
                use_rs = 1'b1;
                use_imm = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::op_lwd: begin
                use_rs = 1'b1;
                use_imm = 1'b1;
                mem_read = 1'b1;
                reg_write = 1'b1;
                mem_to_reg = 1'b1;
            end
            cpu_pkg::op_swd: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                use_imm = 1'b1;
                mem_write = 1'b1;
            end
            default: ;
        endcase
    end

    // Register read, with the writeback value bypassed.
    always_comb begin
        rdata1 = regs[rs];
        rdata2 = regs[rt];
        if (wb_reg_write && wb_rd == rs) rdata1 = wb_data;
        if (wb_reg_write && wb_rd == rt) rdata2 = wb_data;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Hazard stall.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign hazard_ex = de.reg_write && ((use_rs && de.rd == rs) || (use_rt && de.rd == rt));
    assign hazard_mem = mem_reg_write && ((use_rs && mem_rd == rs) || (use_rt && mem_rd == rt));
    // Keeps a gap between output port pulses.
    assign wwd_gap = is_wwd && de.is_wwd;
    assign stall = hazard_ex || hazard_mem || wwd_gap;
    assign issue = !stall && !halt_seen;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc <= pc_reset;
            halt_seen <= 1'b0;
        end else if (issue) begin
            if (is_done) begin
                halt_seen <= 1'b1;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            regs <= '{default: '0};
        end else if (wb_reg_write) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // ID/EX register. Bubble on stall or after halt.
    always_ff @(posedge clk) begin
        if (reset_n || !issue) begin
            de.mem_read <= 1'b0;
            de.mem_write <= 1'b0;
            de.reg_write <= 1'b0;
            de.mem_to_reg <= 1'b0;
            de.is_wwd <= 1'b0;
            de.is_done <= 1'b0;
        end else begin
            de.mem_read <= mem_read;
            de.mem_write <= mem_write;
            de.reg_write <= reg_write;
            de.mem_to_reg <= mem_to_reg;
            de.is_wwd <= is_wwd;
            de.is_done <= is_done;
        end
        de.r_data1 <= rdata1;
        de.r_data2 <= rdata2;
        de.imm <= imm;
        de.alu_op <= alu_op;
        de.use_imm <= use_imm;
        de.rd <= dest;
    end

endmodule

// ==== ex_stage.sv ====
module ex_stage (
    id_ex_if.consumer  de,
    ex_mem_if.producer em
);

    logic [cpu_pkg::word_size-1:0] operand_b;

    assign operand_b = de.use_imm ? de.imm : de.r_data2;

    // Also the memory address for LWD and SWD.
    always_comb begin
        case (de.alu_op)
            cpu_pkg::alu_sub: em.alu_result = de.r_data1 - operand_b;
            cpu_pkg::alu_and: em.alu_result = de.r_data1 & operand_b;
            cpu_pkg::alu_orr: em.alu_result = de.r_data1 | operand_b;
            default:          em.alu_result = de.r_data1 + operand_b;
        endcase
    end

    assign em.r_data1 = de.r_data1;
    assign em.r_data2 = de.r_data2;
    assign em.rd = de.rd;

    assign em.mem_read = de.mem_read;
    assign em.mem_write = de.mem_write;
    assign em.reg_write = de.reg_write;
    assign em.mem_to_reg = de.mem_to_reg;
    assign em.is_wwd = de.is_wwd;
    assign em.is_done = de.is_done;

endmodule

// ==== ex_mem_reg.sv ====
module ex_mem_reg (
    input logic        clk,
    input logic        reset_n,
    ex_mem_if.consumer d,
    ex_mem_if.producer q
);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            q.alu_result <= '0;
            q.r_data1 <= '0;
            q.r_data2 <= '0;
            q.rd <= '0;
            q.mem_read <= 1'b0;
            q.mem_write <= 1'b0;
            q.reg_write <= 1'b0;
            q.mem_to_reg <= 1'b0;
            q.is_wwd <= 1'b0;
            q.is_done <= 1'b0;
        end else begin
            q.alu_result <= d.alu_result;
            q.r_data1 <= d.r_data1;
            q.r_data2 <= d.r_data2;
            // Decode reads rd and reg_write here for the MEM hazard.
            q.rd <= d.rd;
            q.mem_read <= d.mem_read;
            q.mem_write <= d.mem_write;
            q.reg_write <= d.reg_write;
            q.mem_to_reg <= d.mem_to_reg;
            q.is_wwd <= d.is_wwd;
            q.is_done <= d.is_done;
        end
    end

endmodule

// ==== mem_wb_stage.sv ====
module mem_wb_stage (
    input  logic                              clk,
    input  logic                              reset_n,
    ex_mem_if.consumer                        em,
    input  logic [cpu_pkg::word_size-1:0]     d_rdata,
    output logic [cpu_pkg::word_size-1:0]     d_addr,
    output logic [cpu_pkg::word_size-1:0]     d_wdata,
    output logic                              d_read,
    output logic                              d_write,
    output logic                              wb_reg_write,
    output logic [cpu_pkg::reg_addr_bits-1:0] wb_rd,
    output logic [cpu_pkg::word_size-1:0]     wb_data,
    output logic [cpu_pkg::word_size-1:0]     out_port,
    output logic                              out_valid,
    output logic                              halted
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MEM stage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign d_addr = em.alu_result;
    assign d_wdata = em.r_data2;
    assign d_read = em.mem_read;
    assign d_write = em.mem_write;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MEM/WB register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb_reg_write <= 1'b0;
            out_valid <= 1'b0;
            halted <= 1'b0;
        end else begin
            wb_reg_write <= em.reg_write;
            out_valid <= em.is_wwd;
            // Sticky until reset.
            halted <= halted || em.is_done;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd <= em.rd;
        wb_data <= em.mem_to_reg ? d_rdata : em.alu_result;
        out_port <= em.r_data1;
    end

endmodule

// ==== cpu_top.sv ====
module cpu_top #(
    parameter logic [cpu_pkg::word_size-1:0] pc_reset = '0
) (
    input  logic                          clk,
    input  logic                          reset_n,
    output logic [cpu_pkg::word_size-1:0] i_addr,
    input  logic [cpu_pkg::word_size-1:0] i_data,
    output logic [cpu_pkg::word_size-1:0] d_addr,
    output logic [cpu_pkg::word_size-1:0] d_wdata,
    output logic                          d_read,
    output logic                          d_write,
    input  logic [cpu_pkg::word_size-1:0] d_rdata,
    output logic [cpu_pkg::word_size-1:0] out_port,
    output logic                          out_valid,
    output logic                          halted
);

    logic                              wb_reg_write;
    logic [cpu_pkg::reg_addr_bits-1:0] wb_rd;
    logic [cpu_pkg::word_size-1:0]     wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem_d ();
    ex_mem_if ex_mem_q ();

    id_stage #(
        .pc_reset(pc_reset)
    ) u_id_stage (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_data       (i_data),
        .mem_reg_write(ex_mem_q.reg_write),
        .mem_rd       (ex_mem_q.rd),
        .wb_reg_write (wb_reg_write),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .i_addr       (i_addr),
        .de           (id_ex)
    );

    ex_stage u_ex_stage (
        .de(id_ex),
        .em(ex_mem_d)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk    (clk),
        .reset_n(reset_n),
        .d      (ex_mem_d),
        .q      (ex_mem_q)
    );

    mem_wb_stage u_mem_wb_stage (
        .clk         (clk),
        .reset_n     (reset_n),
        .em          (ex_mem_q),
        .d_rdata     (d_rdata),
        .d_addr      (d_addr),
        .d_wdata     (d_wdata),
        .d_read      (d_read),
        .d_write     (d_write),
        .wb_reg_write(wb_reg_write),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .out_port    (out_port),
        .out_valid   (out_valid),
        .halted      (halted)
    );

endmodule

// ==== cpu_properties.sv ====
module cpu_properties (
    input logic clk,
    input logic reset_n,
    input logic d_read,
    input logic d_write,
    input logic out_valid,
    input logic halted
);

    timeunit 1ns;
    timeprecision 100ps;

    // Data memory is either read or written.
    assert property (@(posedge clk) disable iff (reset_n) !(d_read && d_write))
        else begin
            tb_cpu.prop_errs++;
            $error("d_read and d_write high in the same cycle");
        end

    assert property (@(posedge clk) disable iff (reset_n) out_valid |=> !out_valid)
        else begin
            tb_cpu.prop_errs++;
            $error("out_valid high for two cycles in a row");
        end

    // Sticky halt with an empty pipeline behind it.
    assert property (@(posedge clk) disable iff (reset_n)
                     halted |=> halted && !d_read && !d_write && !out_valid)
        else begin
            tb_cpu.prop_errs++;
            $error("halted fell without reset or pipeline still active after halt");
        end

endmodule

// ==== tb_cpu.sv ====
module tb_cpu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int w = cpu_pkg::word_size;
    localparam int prog_len = 60;
    localparam int timeout_cycles = 2000;
    localparam logic [w-1:0] pc_start = '0;

    logic         clk;
    logic         reset_n;
    logic [w-1:0] i_addr, i_data;
    logic [w-1:0] d_addr, d_wdata, d_rdata;
    logic [w-1:0] out_port;
    logic         d_read, d_write, out_valid, halted;

    logic [w-1:0] imem [256];
    logic [w-1:0] dmem [256];
    logic [w-1:0] model_mem [256];
    logic [w-1:0] exp_out [$];
    logic [w-1:0] exp_st_addr [$];
    logic [w-1:0] exp_st_data [$];
    logic [w-1:0] exp_ld_addr [$];
    logic [31:0]  rng;
    int           value_errs;
    int           other_errs;
    int           prop_errs;

    cpu_top #(
        .pc_reset(pc_start)
    ) DUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_addr   (i_addr),
        .i_data   (i_data),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .d_read   (d_read),
        .d_write  (d_write),
        .d_rdata  (d_rdata),
        .out_port (out_port),
        .out_valid(out_valid),
        .halted   (halted)
    );

    bind mem_wb_stage cpu_properties u_cpu_properties (
        .clk      (clk),
        .reset_n  (reset_n),
        .d_read   (d_read),
        .d_write  (d_write),
        .out_valid(out_valid),
        .halted   (halted)
    );

    always #2 clk = ~clk;

    // Memories answer in the same cycle.
    assign i_data = imem[i_addr[7:0]];
    assign d_rdata = dmem[d_addr[7:0]];

    always @(posedge clk) begin
        if (d_write === 1'b1) dmem[d_addr[7:0]] <= d_wdata;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [w-1:0] fill_word(input logic [7:0] a);
        return {a ^ 8'h3c, ~a};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program generator and ISA model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_program();
        logic [1:0] rs, rt, rd;
        for (int i = 0; i < prog_len - 1; i++) begin
            rng = xorshift(rng);
            rs = rng[9:8];
            rt = rng[11:10];
            rd = rng[13:12];
            case (rng[2:0])
                3'd0: imem[i] = {cpu_pkg::op_rtype, rs, rt, rd, cpu_pkg::fn_add};
                3'd1: imem[i] = {cpu_pkg::op_rtype, rs, rt, rd, cpu_pkg::fn_sub};
                3'd2: imem[i] = {cpu_pkg::op_rtype, rs, rt, rd, cpu_pkg::fn_and};
                3'd3: imem[i] = {cpu_pkg::op_rtype, rs, rt, rd, cpu_pkg::fn_orr};
                3'd4: imem[i] = {cpu_pkg::op_rtype, rs, 4'b0000, cpu_pkg::fn_wwd};
                3'd5: imem[i] = {cpu_pkg::op_adi, rs, rt, rng[23:16]};
                3'd6: imem[i] = {cpu_pkg::op_lwd, rs, rt, rng[23:16]};
                default: imem[i] = {cpu_pkg::op_swd, rs, rt, rng[23:16]};
            endcase
        end
        imem[prog_len-1] = {cpu_pkg::op_rtype, 6'd0, cpu_pkg::fn_hlt};
    endtask

    task automatic run_model();
        logic [w-1:0] regs [4];
        logic [w-1:0] word, a, b, addr;
        regs = '{default: '0};
        for (int i = 0; i < prog_len - 1; i++) begin
            word = imem[i];
            a = regs[word[11:10]];
            b = regs[word[9:8]];
            addr = a + {{8{word[7]}}, word[7:0]};
            case (word[15:12])
                cpu_pkg::op_adi: regs[word[9:8]] = addr;
                cpu_pkg::op_lwd: begin
                    regs[word[9:8]] = model_mem[addr[7:0]];
                    exp_ld_addr.push_back(addr);
                end
                cpu_pkg::op_swd: begin
                    model_mem[addr[7:0]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                default: begin
                    case (word[5:0])
                        cpu_pkg::fn_add: regs[word[7:6]] = a + b;
                        cpu_pkg::fn_sub: regs[word[7:6]] = a - b;
                        cpu_pkg::fn_and: regs[word[7:6]] = a & b;
                        cpu_pkg::fn_orr: regs[word[7:6]] = a | b;
                        default:         exp_out.push_back(a);
                    endcase
                end
            endcase
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output and store monitors.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin : monitor
        logic [w-1:0] exp_val, exp_addr;
        if (reset_n === 1'b0 && out_valid === 1'b1) begin
            assert (exp_out.size() > 0) else begin
                other_errs++;
                $display("Output pulse seen with no WWD left in the program.");
            end
            if (exp_out.size() > 0) begin
                exp_val = exp_out.pop_front();
                assert (out_port === exp_val) else begin
                    value_errs++;
                    $display("ERR out_port: got %h, expected %h", out_port, exp_val);
                end
            end
        end
        if (reset_n === 1'b0 && d_write === 1'b1) begin
            assert (exp_st_addr.size() > 0) else begin
                other_errs++;
                $display("Store seen with no SWD left in the program.");
            end
            if (exp_st_addr.size() > 0) begin
                exp_addr = exp_st_addr.pop_front();
                exp_val = exp_st_data.pop_front();
                assert (d_addr === exp_addr) else begin
                    value_errs++;
                    $display("ERR d_addr: got %h, expected %h", d_addr, exp_addr);
                end
                assert (d_wdata === exp_val) else begin
                    value_errs++;
                    $display("ERR d_wdata: got %h, expected %h", d_wdata, exp_val);
                end
            end
        end
        if (reset_n === 1'b0 && d_read === 1'b1) begin
            assert (exp_ld_addr.size() > 0) else begin
                other_errs++;
                $display("Load seen with no LWD left in the program.");
            end
            if (exp_ld_addr.size() > 0) begin
                exp_addr = exp_ld_addr.pop_front();
                assert (d_addr === exp_addr) else begin
                    value_errs++;
                    $display("ERR d_addr: got %h, expected %h", d_addr, exp_addr);
                end
            end
        end
    end

    task automatic check_final();
        logic [w-1:0] last_pc;
        assert (exp_out.size() == 0) else begin
            other_errs++;
            $display("%0d WWD outputs never appeared.", exp_out.size());
        end
        assert (exp_st_addr.size() == 0) else begin
            other_errs++;
            $display("%0d stores never appeared.", exp_st_addr.size());
        end
        assert (exp_ld_addr.size() == 0) else begin
            other_errs++;
            $display("%0d loads never appeared.", exp_ld_addr.size());
        end
        for (int a = 0; a < 256; a++) begin
            assert (dmem[a] === model_mem[a]) else begin
                value_errs++;
                $display("ERR dmem[%h]: got %h, expected %h", a[7:0], dmem[a], model_mem[a]);
            end
        end
        // Fetch must stay frozen after halt.
        last_pc = i_addr;
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            assert (i_addr === last_pc) else begin
                value_errs++;
                $display("ERR i_addr: got %h, expected %h", i_addr, last_pc);
            end
        end
    endtask

    initial begin : main
        int cycles;
        clk = 1'b0;
        reset_n = 1'b1;
        value_errs = 0;
        other_errs = 0;
        prop_errs = 0;
        rng = 32'he3d4_6d0c;
        for (int a = 0; a < 256; a++) begin
            imem[a] = {cpu_pkg::op_rtype, 6'd0, cpu_pkg::fn_hlt};
            dmem[a] = fill_word(a[7:0]);
            model_mem[a] = dmem[a];
        end
        build_program();
        run_model();

        repeat (3) @(posedge clk);
        reset_n <= 1'b0;
        @(negedge clk);
        assert ({out_valid, d_read, d_write, halted} === 4'b0000) else begin
            value_errs++;
            $display("ERR {out_valid,d_read,d_write,halted}: got %h, expected %h",
                     {out_valid, d_read, d_write, halted}, 4'h0);
        end
        assert (i_addr === pc_start) else begin
            value_errs++;
            $display("ERR i_addr: got %h, expected %h", i_addr, pc_start);
        end

        cycles = 0;
        while (halted !== 1'b1 && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            other_errs++;
            $display("Timeout after %0d cycles, program did not halt.", timeout_cycles);
        end else begin
            check_final();
        end

        $display("Errors: %0d value, %0d other, %0d property", value_errs, other_errs,
                 prop_errs);
        if (value_errs + other_errs + prop_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
cpu_pkg.sv
id_ex_if.sv
ex_mem_if.sv
id_stage.sv
ex_stage.sv
ex_mem_reg.sv
mem_wb_stage.sv
cpu_top.sv
cpu_properties.sv
tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu_pipeline

sources:
  - cpu_pkg.sv
  - id_ex_if.sv
  - ex_mem_if.sv
  - id_stage.sv
  - ex_stage.sv
  - ex_mem_reg.sv
  - mem_wb_stage.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_properties.sv
      - tb_cpu.sv
